//--- all.f
design/ccu_bus_pkg.sv
design/ccu_snoop_pkg.sv
design/ccu_arbiter.sv
design/ccu_ctrl.sv
design/ccu_snoop_unit.sv
design/ccu_mem_path.sv
design/ccu_top.sv
verification/ccu_tb_models.sv
verification/ccu_tb.sv

//--- verification/ccu_tb.sv
`timescale 1ns/1ps

module ccu_tb import ccu_bus_pkg::*, ccu_snoop_pkg::*; ();

  logic                 clk;
  logic                 rst_n;
  logic [NUM_PORTS-1:0] cpu_req;
  logic [NUM_PORTS-1:0] cpu_we;
  addr_t                cpu_addr    [NUM_PORTS];
  data_t                cpu_wdata   [NUM_PORTS];
  port_mask_t           domain_mask [NUM_PORTS];
  logic [NUM_PORTS-1:0] cpu_ack;
  data_t                cpu_rdata   [NUM_PORTS];
  logic [NUM_PORTS-1:0] cpu_shared;
  logic [NUM_PORTS-1:0] snoop_req;
  snoop_op_e            snoop_op    [NUM_PORTS];
  addr_t                snoop_addr  [NUM_PORTS];
  logic [NUM_PORTS-1:0] snoop_ack;
  port_mask_t           snoop_hit;
  data_t                snoop_data  [NUM_PORTS];
  logic                 mem_req;
  logic                 mem_we;
  addr_t                mem_addr;
  data_t                mem_wdata;
  logic                 mem_ack;
  data_t                mem_rdata;

  // Expected response per port, set when the request goes out
  data_t      exp_data   [NUM_PORTS];
  logic       exp_shared [NUM_PORTS];
  logic       exp_read   [NUM_PORTS];
  port_idx_t  done_order [$];
  port_mask_t snooped;    // Peers that saw a snoop since last clear
  port_idx_t  last_port;
  int         err_data;
  int         err_flag;
  int         err_port;
  int         err_proto;
  int         seed;

  ccu_top DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .cpu_req_i (cpu_req), .cpu_we_i (cpu_we), .cpu_addr_i (cpu_addr),
    .cpu_wdata_i (cpu_wdata), .domain_mask_i (domain_mask),
    .cpu_ack_o (cpu_ack), .cpu_rdata_o (cpu_rdata), .cpu_shared_o (cpu_shared),
    .snoop_req_o (snoop_req), .snoop_op_o (snoop_op), .snoop_addr_o (snoop_addr),
    .snoop_ack_i (snoop_ack), .snoop_hit_i (snoop_hit), .snoop_data_i (snoop_data),
    .mem_req_o (mem_req), .mem_we_o (mem_we), .mem_addr_o (mem_addr),
    .mem_wdata_o (mem_wdata), .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata)
  );

  ccu_tb_models u_models (
    .clk_i (clk),
    .snoop_req_i (snoop_req), .snoop_op_i (snoop_op), .snoop_addr_i (snoop_addr),
    .snoop_ack_o (snoop_ack), .snoop_hit_o (snoop_hit), .snoop_data_o (snoop_data),
    .mem_req_i (mem_req), .mem_we_i (mem_we), .mem_addr_i (mem_addr),
    .mem_wdata_i (mem_wdata), .mem_ack_o (mem_ack), .mem_rdata_o (mem_rdata)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      err_flag++;
    end
  endtask

  task automatic check_port(input string name, input port_idx_t got, input port_idx_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      err_port++;
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("ERROR %0t: timed out waiting for %s", $time, what);
    $display("tests failed");
    $finish;
  endtask

  // Lowest masked peer with a valid line wins, memory otherwise
  function automatic data_t ref_read(input port_idx_t p, input addr_t a, input port_mask_t m,
                                     output logic shr);
    data_t d;
    d   = u_models.mem[a];
    shr = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (!shr && m[q] && q != p && u_models.line_valid[q][a[3:0]] &&
          u_models.line_tag[q][a[3:0]] == a) begin
        d   = u_models.line_data[q][a[3:0]];
        shr = 1'b1;
      end
    end
    return d;
  endfunction

  // Peers that must lose the line on a write
  function automatic port_mask_t ref_inval(input port_idx_t p, input port_mask_t m);
    return m & ~(port_mask_t'(1) << p);
  endfunction

  task automatic set_line(input int q, input addr_t a, input data_t d);
    u_models.line_valid[q][a[3:0]] = 1'b1;
    u_models.line_tag[q][a[3:0]]   = a;
    u_models.line_data[q][a[3:0]]  = d;
  endtask

  task automatic start_req(input port_idx_t p, input logic we, input addr_t a, input data_t d,
                           input port_mask_t m);
    logic shr;
    exp_data[p]    = ref_read(p, a, m, shr);
    exp_shared[p]  = we ? 1'b0 : shr;
    exp_read[p]    = !we;
    cpu_we[p]      = we;
    cpu_addr[p]    = a;
    cpu_wdata[p]   = d;
    domain_mask[p] = m;
    cpu_req[p]     = 1'b1;
  endtask

  task automatic finish_req(input port_idx_t p);
    int n;
    n = 0;
    while (!cpu_ack[p] && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_ack[p]) abort_timeout($sformatf("ack to rise on port %0d", p));
    @(posedge clk);
    #2 cpu_req[p] = 1'b0;
    n = 0;
    while (cpu_ack[p] && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (cpu_ack[p]) abort_timeout($sformatf("ack to fall on port %0d", p));
  endtask

  task automatic access(input port_idx_t p, input logic we, input addr_t a, input data_t d,
                        input port_mask_t m);
    @(posedge clk);
    #2 start_req(p, we, a, d, m);
    finish_req(p);
    last_port = p;
  endtask

  // Four reads at once, served round-robin after last_port
  task automatic run_all_ports();
    port_idx_t first;
    first = last_port + 1'b1;
    done_order.delete();
    @(posedge clk);
    #2;
    for (int p = 0; p < NUM_PORTS; p++) begin
      start_req(port_idx_t'(p), 1'b0, addr_t'(16'h0600 + p), '0, '0);
    end
    fork
      finish_req(2'd0);
      finish_req(2'd1);
      finish_req(2'd2);
      finish_req(2'd3);
    join
    for (int i = 0; i < NUM_PORTS; i++) begin
      check_port($sformatf("completion %0d", i), done_order[i], port_idx_t'(first + i));
    end
  endtask

  // Response compare and protocol monitor
  initial begin
    logic [NUM_PORTS-1:0] ack_prev;
    logic [NUM_PORTS-1:0] sreq_prev;
    logic                 mreq_prev;
    ack_prev  = '0;
    sreq_prev = '0;
    mreq_prev = 1'b0;
    forever begin
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (cpu_ack[p] && !ack_prev[p]) begin
          if (!cpu_req[p]) begin
            $display("ERROR %0t: ack on port %0d rose without req", $time, p);
            err_proto++;
          end
          if (exp_read[p]) check_data($sformatf("cpu_rdata_o[%0d]", p), cpu_rdata[p], exp_data[p]);
          check_flag($sformatf("cpu_shared_o[%0d]", p), cpu_shared[p], exp_shared[p]);
          done_order.push_back(port_idx_t'(p));
        end
        if (!cpu_ack[p] && ack_prev[p] && cpu_req[p]) begin
          $display("ERROR %0t: ack on port %0d fell while req was high", $time, p);
          err_proto++;
        end
        if (sreq_prev[p] && !snoop_req[p] && !snoop_ack[p]) begin
          $display("ERROR %0t: snoop req to peer %0d dropped before ack", $time, p);
          err_proto++;
        end
      end
      if (mreq_prev && !mem_req && !mem_ack) begin
        $display("ERROR %0t: memory req dropped before ack", $time);
        err_proto++;
      end
      snooped   = snooped | snoop_req;
      ack_prev  = cpu_ack;
      sreq_prev = snoop_req;
      mreq_prev = mem_req;
    end
  end

  initial begin
    int         n_mem;
    port_mask_t keep;
    port_idx_t  p;
    addr_t      a;
    data_t      d;
    int         q;
    seed      = 32'h0946_5efc;
    err_data  = 0;
    err_flag  = 0;
    err_port  = 0;
    err_proto = 0;
    snooped   = '0;
    last_port = 2'd3;  // Port 0 first after reset
    cpu_req   = '0;
    cpu_we    = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      cpu_addr[i]    = '0;
      cpu_wdata[i]   = '0;
      domain_mask[i] = '0;
      exp_data[i]    = '0;
      exp_shared[i]  = 1'b0;
      exp_read[i]    = 1'b0;
    end
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    check_flag("cpu_ack_o after reset", |cpu_ack, 1'b0);
    check_flag("cpu_shared_o after reset", |cpu_shared, 1'b0);
    check_flag("snoop_req_o after reset", |snoop_req, 1'b0);
    check_flag("mem_req_o after reset", mem_req, 1'b0);

    run_all_ports();

    // Read miss
    n_mem = u_models.mem_accesses;
    access(2'd0, 1'b0, 16'h0101, '0, 4'b1110);
    check_flag("one memory access on miss", u_models.mem_accesses == n_mem + 1, 1'b1);

    // Read hit in peers 2 and 3
    set_line(2, 16'h0222, 32'h2222_aaaa);
    set_line(3, 16'h0222, 32'h3333_bbbb);
    n_mem = u_models.mem_accesses;
    access(2'd0, 1'b0, 16'h0222, '0, 4'b1110);
    check_flag("no memory access on hit", u_models.mem_accesses == n_mem, 1'b1);

    // Unmasked peer and requester itself stay quiet
    set_line(1, 16'h0333, 32'h1111_cccc);
    set_line(3, 16'h0333, 32'h3333_cccc);
    snooped = '0;
    access(2'd3, 1'b0, 16'h0333, '0, 4'b1011 & 4'b1001);
    check_flag("peer 1 snooped", snooped[1], 1'b0);
    check_flag("peer 3 snooped", snooped[3], 1'b0);

    // Write invalidates masked peers only
    set_line(1, 16'h0444, 32'h1111_dddd);
    set_line(2, 16'h0444, 32'h2222_dddd);
    set_line(3, 16'h0444, 32'h3333_dddd);
    keep = 4'b1110 & ~ref_inval(2'd0, 4'b0110);
    access(2'd0, 1'b1, 16'h0444, 32'hdead_beef, 4'b0110);
    for (int i = 1; i < NUM_PORTS; i++) begin
      check_flag($sformatf("peer %0d line valid", i), u_models.line_valid[i][4], keep[i]);
    end
    check_data("memory word 0444", u_models.mem[16'h0444], 32'hdead_beef);
    // Only the invalidated peer 2 and the empty peer 0 are masked, so memory serves it
    n_mem = u_models.mem_accesses;
    access(2'd3, 1'b0, 16'h0444, '0, 4'b0101);
    check_flag("memory access on read after write", u_models.mem_accesses == n_mem + 1, 1'b1);

    access(2'd1, 1'b0, 16'h0555, '0, '0);
    run_all_ports();

    // Random traffic with random model delays
    for (int i = 0; i < 40; i++) begin
      p = port_idx_t'($random(seed));
      a = addr_t'(16'h0700 + ($random(seed) & 3) * 16'h11);
      if ($random(seed) & 1) begin
        q = $random(seed) & 3;
        d = $random(seed);
        set_line(q, a, d);
      end
      d = $random(seed);
      access(p, ($random(seed) & 3) == 0, a, d, port_mask_t'($random(seed)));
    end

    repeat (5) @(posedge clk);
    $display("errors: data %0d, flag %0d, port %0d, protocol %0d, stuck handshakes %0d",
             err_data, err_flag, err_port, err_proto, u_models.stuck_cnt);
    if (err_data + err_flag + err_port + err_proto + u_models.stuck_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verification/ccu_tb_models.sv
`timescale 1ns/1ps

module ccu_tb_models import ccu_bus_pkg::*, ccu_snoop_pkg::*; (
  input  logic                 clk_i,
  input  logic [NUM_PORTS-1:0] snoop_req_i,
  input  snoop_op_e            snoop_op_i   [NUM_PORTS],
  input  addr_t                snoop_addr_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0] snoop_ack_o,
  output port_mask_t           snoop_hit_o,
  output data_t                snoop_data_o [NUM_PORTS],
  input  logic                 mem_req_i,
  input  logic                 mem_we_i,
  input  addr_t                mem_addr_i,
  input  data_t                mem_wdata_i,
  output logic                 mem_ack_o,
  output data_t                mem_rdata_o
);

  // Peer line tables, indexed by addr[3:0]
  logic  line_valid [NUM_PORTS][16];
  addr_t line_tag   [NUM_PORTS][16];
  data_t line_data  [NUM_PORTS][16];

  data_t mem [0:65535];
  int    mem_accesses;
  int    stuck_cnt;  // Handshakes where req never dropped
  int    seed;

  function automatic int rand_delay();
    return $random(seed) & 3;
  endfunction

  initial begin
    seed         = 32'h0946_5efc;
    mem_accesses = 0;
    stuck_cnt    = 0;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {~i[15:0], i[15:0]} ^ 32'h0f0f_3c3c;
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int i = 0; i < 16; i++) begin
        line_valid[q][i] = 1'b0;
        line_tag[q][i]   = '0;
        line_data[q][i]  = '0;
      end
    end
  end

  for (genvar q = 0; q < NUM_PORTS; q++) begin : g_peer
    initial begin
      int         n;
      logic [3:0] idx;
      snoop_ack_o[q]  = 1'b0;
      snoop_hit_o[q]  = 1'b0;
      snoop_data_o[q] = '0;
      forever begin
        @(posedge clk_i);
        if (snoop_req_i[q]) begin
          repeat (rand_delay()) @(posedge clk_i);
          #2;
          idx = snoop_addr_i[q][3:0];
          snoop_hit_o[q]  = line_valid[q][idx] && (line_tag[q][idx] == snoop_addr_i[q]);
          snoop_data_o[q] = line_data[q][idx];
          if (snoop_op_i[q] == SNOOP_INVALIDATE && snoop_hit_o[q]) begin
            line_valid[q][idx] = 1'b0; // Line dropped on invalidate
          end
          snoop_ack_o[q] = 1'b1;
          n = 0;
          while (snoop_req_i[q] && n < 200) begin
            @(posedge clk_i);
            n++;
          end
          if (snoop_req_i[q]) stuck_cnt++;
          repeat (rand_delay()) @(posedge clk_i);
          #2 snoop_ack_o[q] = 1'b0;
        end
      end
    end
  end

  initial begin
    int n;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    forever begin
      @(posedge clk_i);
      if (mem_req_i) begin
        repeat (rand_delay()) @(posedge clk_i);
        #2;
        if (mem_we_i) mem[mem_addr_i] = mem_wdata_i;
        else mem_rdata_o = mem[mem_addr_i];
        mem_accesses++;
        mem_ack_o = 1'b1;
        n = 0;
        while (mem_req_i && n < 200) begin
          @(posedge clk_i);
          n++;
        end
        if (mem_req_i) stuck_cnt++;
        repeat (rand_delay()) @(posedge clk_i);
        #2 mem_ack_o = 1'b0;
      end
    end
  end

endmodule

//--- design/ccu_top.sv
`timescale 1ns/1ps

module ccu_top import ccu_bus_pkg::*, ccu_snoop_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NUM_PORTS-1:0] cpu_req_i,
  input  logic [NUM_PORTS-1:0] cpu_we_i,
  input  addr_t                cpu_addr_i    [NUM_PORTS],
  input  data_t                cpu_wdata_i   [NUM_PORTS],
  input  port_mask_t           domain_mask_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0] cpu_ack_o,
  output data_t                cpu_rdata_o   [NUM_PORTS],
  output logic [NUM_PORTS-1:0] cpu_shared_o,
  output logic [NUM_PORTS-1:0] snoop_req_o,
  output snoop_op_e            snoop_op_o    [NUM_PORTS],
  output addr_t                snoop_addr_o  [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] snoop_ack_i,
  input  port_mask_t           snoop_hit_i,
  input  data_t                snoop_data_i  [NUM_PORTS],
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output addr_t                mem_addr_o,
  output data_t                mem_wdata_o,
  input  logic                 mem_ack_i,
  input  data_t                mem_rdata_i
);

  logic      gnt_valid;
  port_idx_t gnt_idx;
  logic      gnt_done;
  port_idx_t sel_idx;
  logic      shared;

  logic      snp_start;
  snoop_op_e snp_op;
  logic      snp_done;
  logic      snp_hit;
  data_t     snp_data;

  logic      mem_start;
  logic      mem_we;
  logic      mem_done;
  data_t     mem_data;

  ccu_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (cpu_req_i),
    .done_i      (gnt_done),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  ccu_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .gnt_valid_i (gnt_valid),
    .gnt_idx_i   (gnt_idx),
    .gnt_done_o  (gnt_done),
    .cpu_req_i   (cpu_req_i),
    .cpu_we_i    (cpu_we_i[sel_idx]),
    .cpu_ack_o   (cpu_ack_o),
    .snp_start_o (snp_start),
    .snp_op_o    (snp_op),
    .snp_done_i  (snp_done),
    .snp_hit_i   (snp_hit),
    .mem_start_o (mem_start),
    .mem_we_o    (mem_we),
    .mem_done_i  (mem_done),
    .sel_idx_o   (sel_idx),
    .shared_o    (shared)
  );

  ccu_snoop_unit i_snoop_unit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (snp_start),
    .op_i          (snp_op),
    .req_idx_i     (sel_idx),
    .domain_mask_i (domain_mask_i[sel_idx]),
    .addr_i        (cpu_addr_i[sel_idx]),
    .done_o        (snp_done),
    .hit_o         (snp_hit),
    .data_o        (snp_data),
    .snoop_req_o   (snoop_req_o),
    .snoop_op_o    (snoop_op_o),
    .snoop_addr_o  (snoop_addr_o),
    .snoop_ack_i   (snoop_ack_i),
    .snoop_hit_i   (snoop_hit_i),
    .snoop_data_i  (snoop_data_i)
  );

  ccu_mem_path i_mem_path (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (mem_start),
    .we_i        (mem_we),
    .addr_i      (cpu_addr_i[sel_idx]),
    .wdata_i     (cpu_wdata_i[sel_idx]),
    .done_o      (mem_done),
    .rdata_o     (mem_data),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  // Read result goes to every port, only the acked one takes it
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_resp
    assign cpu_rdata_o[p]  = shared ? snp_data : mem_data;
    assign cpu_shared_o[p] = shared && (sel_idx == port_idx_t'(p));
  end

endmodule

//--- design/ccu_mem_path.sv
`timescale 1ns/1ps

module ccu_mem_path import ccu_bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  start_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output logic  done_o,
  output data_t rdata_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  input  logic  mem_ack_i,
  input  data_t mem_rdata_i
);

  logic  req_q;
  logic  wait_q;  // ack seen, waiting for it to fall
  logic  we_q;
  addr_t addr_q;
  data_t wdata_q;
  data_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (start_i) begin
        req_q <= 1'b1;
      end else if (req_q && mem_ack_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end else if (wait_q && !mem_ack_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (req_q && mem_ack_i) rdata_q <= mem_rdata_i;
  end

  assign done_o      = wait_q && !mem_ack_i;
  assign rdata_o     = rdata_q;
  assign mem_req_o   = req_q;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;

  // No restart from the controller mid-cycle
  a_mem_fields_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && $past(mem_req_o) |-> $stable({mem_we_o, mem_addr_o, mem_wdata_o}));

endmodule

//--- design/ccu_snoop_unit.sv
`timescale 1ns/1ps

module ccu_snoop_unit import ccu_bus_pkg::*, ccu_snoop_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  snoop_op_e            op_i,
  input  port_idx_t            req_idx_i,
  input  port_mask_t           domain_mask_i,
  input  addr_t                addr_i,
  output logic                 done_o,
  output logic                 hit_o,
  output data_t                data_o,
  output logic [NUM_PORTS-1:0] snoop_req_o,
  output snoop_op_e            snoop_op_o   [NUM_PORTS],
  output addr_t                snoop_addr_o [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] snoop_ack_i,
  input  port_mask_t           snoop_hit_i,
  input  data_t                snoop_data_i [NUM_PORTS]
);

  logic                 busy_q;
  snoop_op_e            op_q;
  addr_t                addr_q;
  port_mask_t           sel_mask;
  port_mask_t           sel_q;     // Peers taking part
  logic [NUM_PORTS-1:0] req_q;
  port_mask_t           hit_vec_q;
  data_t                data_q [NUM_PORTS];

  // Requester never snoops itself
  assign sel_mask = domain_mask_i & ~(port_mask_t'(1) << req_idx_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      op_q      <= SNOOP_READ_CLEAN;
      addr_q    <= '0;
      sel_q     <= '0;
      req_q     <= '0;
      hit_vec_q <= '0;
    end else if (start_i) begin
      busy_q    <= 1'b1;
      op_q      <= op_i;
      addr_q    <= addr_i;
      sel_q     <= sel_mask;
      req_q     <= sel_mask;
      hit_vec_q <= '0;
    end else if (busy_q) begin
      if (done_o) busy_q <= 1'b0;
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (req_q[q] && snoop_ack_i[q]) begin
          req_q[q]     <= 1'b0; // ack seen, drop req
          hit_vec_q[q] <= snoop_hit_i[q];
        end
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (req_q[q] && snoop_ack_i[q]) data_q[q] <= snoop_data_i[q];
    end
  end

  // All reqs dropped and every selected peer has released its ack
  assign done_o = busy_q && (req_q == '0) && !(|(snoop_ack_i & sel_q));
  assign hit_o  = |hit_vec_q;

  // Lowest-indexed hit wins
  always_comb begin
    data_o = '0;
    for (int q = NUM_PORTS - 1; q >= 0; q--) begin
      if (hit_vec_q[q]) data_o = data_q[q];
    end
  end

  assign snoop_req_o = req_q;
  for (genvar q = 0; q < NUM_PORTS; q++) begin : g_bcast
    assign snoop_op_o[q]   = op_q;
    assign snoop_addr_o[q] = addr_q;
  end

  a_no_self_snoop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_q |-> !snoop_req_o[req_idx_i]);

endmodule

//--- design/ccu_ctrl.sv
`timescale 1ns/1ps

module ccu_ctrl import ccu_bus_pkg::*, ccu_snoop_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 gnt_valid_i,
  input  port_idx_t            gnt_idx_i,
  output logic                 gnt_done_o,
  input  logic [NUM_PORTS-1:0] cpu_req_i,
  input  logic                 cpu_we_i,   // we of the selected port
  output logic [NUM_PORTS-1:0] cpu_ack_o,
  output logic                 snp_start_o,
  output snoop_op_e            snp_op_o,
  input  logic                 snp_done_i,
  input  logic                 snp_hit_i,
  output logic                 mem_start_o,
  output logic                 mem_we_o,
  input  logic                 mem_done_i,
  output port_idx_t            sel_idx_o,
  output logic                 shared_o
);

  enum logic [2:0] {
    IDLE,
    SNOOP,
    MEM,
    ACK,
    RELEASE
  } state_q, state_d;

  port_idx_t            sel_q;
  logic                 snp_start_q;
  logic                 mem_start_q;
  logic                 shared_q;
  logic [NUM_PORTS-1:0] ack_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (gnt_valid_i) state_d = SNOOP;
      SNOOP: begin
        if (snp_done_i) begin
          if (!cpu_we_i && snp_hit_i) state_d = ACK; // served by a peer
          else                        state_d = MEM;
        end
      end
      MEM:     if (mem_done_i) state_d = ACK;
      ACK:     if (!cpu_req_i[sel_q]) state_d = RELEASE;
      RELEASE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      sel_q       <= '0;
      snp_start_q <= 1'b0;
      mem_start_q <= 1'b0;
      shared_q    <= 1'b0;
      ack_q       <= '0;
    end else begin
      state_q     <= state_d;
      snp_start_q <= 1'b0;
      mem_start_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (gnt_valid_i) begin
            sel_q       <= gnt_idx_i;
            snp_start_q <= 1'b1; // snoop fires in first SNOOP cycle
          end
        end
        SNOOP: begin
          if (snp_done_i) begin
            if (!cpu_we_i && snp_hit_i) begin
              shared_q     <= 1'b1;
              ack_q[sel_q] <= 1'b1;
            end else begin
              mem_start_q <= 1'b1;
            end
          end
        end
        MEM: if (mem_done_i) ack_q[sel_q] <= 1'b1;
        RELEASE: begin
          ack_q    <= '0;
          shared_q <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  assign gnt_done_o  = (state_q == RELEASE);
  assign snp_start_o = snp_start_q;
  assign snp_op_o    = cpu_we_i ? SNOOP_INVALIDATE : SNOOP_READ_CLEAN;
  assign mem_start_o = mem_start_q;
  assign mem_we_o    = cpu_we_i;
  assign sel_idx_o   = sel_q;
  assign shared_o    = shared_q;
  assign cpu_ack_o   = ack_q;

  // Four-phase rule on the master side, per port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ack_chk
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(cpu_ack_o[p]) |-> cpu_req_i[p]);
  end

endmodule

//--- design/ccu_arbiter.sv
`timescale 1ns/1ps

module ccu_arbiter import ccu_bus_pkg::*, ccu_snoop_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  port_mask_t req_i,
  input  logic       done_i,
  output logic       gnt_valid_o,
  output port_idx_t  gnt_idx_o
);

  logic      gnt_valid_q;
  port_idx_t gnt_idx_q;
  port_idx_t last_q;     // Last winner
  port_idx_t next_idx;
  port_idx_t cand;

  // Search starts one past the last winner, wraps around
  always_comb begin : pick
    logic found;
    found    = 1'b0;
    next_idx = last_q;
    cand     = last_q;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      cand = last_q + port_idx_t'(i);
      if (!found && req_i[cand]) begin
        next_idx = cand;
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= '0;
      last_q      <= port_idx_t'(NUM_PORTS - 1); // port 0 wins first
    end else if (gnt_valid_q) begin
      if (done_i) begin
        gnt_valid_q <= 1'b0;
        last_q      <= gnt_idx_q;
      end
    end else if (|req_i) begin
      gnt_valid_q <= 1'b1;
      gnt_idx_q   <= next_idx;
    end
  end

  assign gnt_valid_o = gnt_valid_q;
  assign gnt_idx_o   = gnt_idx_q;

  // Grant must not move under the controller
  a_gnt_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_valid_o && $past(gnt_valid_o) |-> $stable(gnt_idx_o));

endmodule

//--- design/ccu_snoop_pkg.sv
package ccu_snoop_pkg;

  // Kind of snoop sent to a peer cache.
  // A read asks for clean data, a write asks the peer to drop its line.
  typedef enum logic {
    SNOOP_READ_CLEAN = 1'b0,
    SNOOP_INVALIDATE = 1'b1
  } snoop_op_e;

  // One bit per master port, used as domain mask and hit vector
  typedef logic [ccu_bus_pkg::NUM_PORTS-1:0] port_mask_t;

endpackage

//--- design/ccu_bus_pkg.sv
package ccu_bus_pkg;

  // Master ports sharing the memory
  localparam int unsigned NUM_PORTS = 4;

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // Bits needed to name one master port
  localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage
